//--- eth_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared MAC types: byte stream struct, FSM state enums,
// frame constants and the CRC-32 byte step
// ~~~~~~~~~~~~~~~~~~~~

package eth_pkg;

   // One byte between pipeline stages
   typedef struct packed {
      logic       vld;   // Byte present this cycle
      logic       sof;   // First byte after SFD
      logic       eof;   // Frame ended, no data
      logic [7:0] data;
   } eth_byte_t;

   // Framer states, named after the byte being sent
   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_DATA,
      TX_FCS
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_HUNT,   // Waiting for SFD
      RX_LOW,    // Next nibble is low half
      RX_HIGH,   // Next nibble completes the byte
      RX_DROP    // Carrier lost before any SFD
   } rx_state_e;

   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam int         PREAMBLE_LEN  = 7;   // Preamble bytes before SFD

   localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;   // Good frame + FCS
   localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;   // Reflected 802.3 poly

   // Advance reflected CRC-32 by one byte, LSB first
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc,
                                              input logic [7:0]  data);
      logic [31:0] c;
      c = crc ^ {24'h0, data};
      for (int i = 0; i < 8; i++) begin
         if (c[0]) begin
            c = (c >> 1) ^ CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

endpackage

//--- eth_tx_framer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Transmit buffer and framer FSM
// Preamble, SFD, payload and optional FCS bytes
// ~~~~~~~~~~~~~~~~~~~~

module eth_tx_framer #(
   parameter int BUFFER_W = 6
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                tx_wr_i,
   input  logic [BUFFER_W-1:0] tx_addr_i,
   input  logic [7:0]          tx_data_i,
   input  logic                send_i,
   input  logic [BUFFER_W:0]   tx_nbytes_i,
   input  logic                tx_crc_en_i,
   input  logic                tx_busy_i,     // Serializer still driving pins
   output logic                tx_ready_o,
   output eth_pkg::eth_byte_t  tx_byte_o
);
   import eth_pkg::*;

   logic [7:0]        tx_mem [2**BUFFER_W];
   tx_state_e         state_q;
   logic [BUFFER_W:0] cnt_q;      // Bytes sent in current field
   logic [BUFFER_W:0] nbytes_q;
   logic              crc_en_q;
   logic              pace_q;     // High on cycles that issue a byte
   logic              ready_q;
   logic [31:0]       crc_q;
   eth_byte_t         byte_q;
   logic [7:0]        rd_data;
   logic [31:0]       fcs;

   assign rd_data    = tx_mem[cnt_q[BUFFER_W-1:0]];   // Async read, payload index
   assign fcs        = ~crc_q;
   assign tx_ready_o = ready_q;
   assign tx_byte_o  = byte_q;

   // Host write port
   always_ff @(posedge clk_i) begin
      if (tx_wr_i) begin
         tx_mem[tx_addr_i] <= tx_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= TX_IDLE;
         cnt_q      <= '0;
         pace_q     <= 1'b0;
         ready_q    <= 1'b1;
         crc_en_q   <= 1'b0;
         byte_q.vld <= 1'b0;
         byte_q.sof <= 1'b0;
         byte_q.eof <= 1'b0;
      end else begin
         byte_q.vld <= 1'b0;
         byte_q.sof <= 1'b0;
         byte_q.eof <= 1'b0;
         if (state_q == TX_IDLE) begin
            if (send_i && ready_q) begin
               state_q     <= TX_PREAMBLE;   // First preamble byte goes out now
               cnt_q       <= {{BUFFER_W{1'b0}}, 1'b1};
               nbytes_q    <= tx_nbytes_i;
               crc_en_q    <= tx_crc_en_i;
               crc_q       <= CRC_INIT;
               pace_q      <= 1'b0;
               ready_q     <= 1'b0;
               byte_q.vld  <= 1'b1;
               byte_q.data <= PREAMBLE_BYTE;
            end else if (!tx_busy_i) begin
               ready_q <= 1'b1;   // Last nibble has left the pins
            end
         end else if (!pace_q) begin
            pace_q <= 1'b1;       // Gap cycle, serializer sends high nibble
         end else begin
            pace_q     <= 1'b0;
            byte_q.vld <= 1'b1;
            case (state_q)
               TX_PREAMBLE: begin
                  if (int'(cnt_q) < PREAMBLE_LEN) begin
                     byte_q.data <= PREAMBLE_BYTE;
                     cnt_q       <= cnt_q + 1'b1;
                  end else begin
                     byte_q.data <= SFD_BYTE;
                     state_q     <= TX_SFD;
                     cnt_q       <= '0;
                  end
               end
               TX_SFD, TX_DATA: begin
                  if (cnt_q < nbytes_q) begin
                     byte_q.data <= rd_data;
                     byte_q.sof  <= (state_q == TX_SFD);
                     crc_q       <= crc32_byte(crc_q, rd_data);   // Payload only
                     state_q     <= TX_DATA;
                     cnt_q       <= cnt_q + 1'b1;
                  end else if (crc_en_q) begin
                     byte_q.data <= fcs[7:0];   // FCS LSB first
                     byte_q.sof  <= (state_q == TX_SFD);
                     state_q     <= TX_FCS;
                     cnt_q       <= {{BUFFER_W{1'b0}}, 1'b1};
                  end else begin
                     state_q    <= TX_IDLE;
                     byte_q.vld <= 1'b0;
                     byte_q.eof <= 1'b1;
                  end
               end
               TX_FCS: begin
                  if (cnt_q < (BUFFER_W + 1)'(4)) begin
                     byte_q.data <= fcs[{cnt_q[1:0], 3'b000} +: 8];
                     cnt_q       <= cnt_q + 1'b1;
                  end else begin
                     state_q    <= TX_IDLE;   // Ready waits for busy to drop
                     byte_q.vld <= 1'b0;
                     byte_q.eof <= 1'b1;
                  end
               end
               default: state_q <= TX_IDLE;
            endcase
         end
      end
   end

endmodule

//--- eth_mii_tx.sv
// ~~~~~~~~~~~~~~~~~~~~
// MII transmit nibble serializer
// ~~~~~~~~~~~~~~~~~~~~

module eth_mii_tx (
   input  logic               clk_i,
   input  logic               reset_i,
   input  eth_pkg::eth_byte_t tx_byte_i,
   output logic               mii_tx_en_o,
   output logic [3:0]         mii_txd_o,
   output logic               tx_busy_o
);

   logic [7:0] data_q;
   logic       en_q;
   logic       hi_q;   // High nibble on the pins

   always_ff @(posedge clk_i) begin
      if (tx_byte_i.vld) begin
         data_q <= tx_byte_i.data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         en_q <= 1'b0;
         hi_q <= 1'b0;
      end else if (tx_byte_i.vld) begin
         en_q <= 1'b1;   // New byte, low nibble next cycle
         hi_q <= 1'b0;
      end else if (en_q && !hi_q) begin
         hi_q <= 1'b1;
      end else begin
         en_q <= 1'b0;   // No follow-on byte, end of frame
         hi_q <= 1'b0;
      end
   end

   assign mii_tx_en_o = en_q;
   assign mii_txd_o   = hi_q ? data_q[7:4] : data_q[3:0];
   assign tx_busy_o   = en_q;   // Fed back to framer

endmodule

//--- eth_mii_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// MII receive stage, SFD hunt and byte assembly
// ~~~~~~~~~~~~~~~~~~~~

module eth_mii_rx (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               mii_rx_dv_i,
   input  logic [3:0]         mii_rxd_i,
   output eth_pkg::eth_byte_t rx_byte_o
);
   import eth_pkg::*;

   rx_state_e  state_q;
   logic       dv_q;      // rx_dv one cycle back
   logic [3:0] nib_q;     // Previous nibble
   logic [3:0] low_q;     // Low half of byte in progress
   logic       first_q;   // Next byte is the first after SFD
   eth_byte_t  byte_q;
   logic       sfd_seen;

   // SFD arrives as 5 then D
   assign sfd_seen = mii_rx_dv_i && dv_q && (nib_q == SFD_BYTE[3:0]) &&
                     (mii_rxd_i == SFD_BYTE[7:4]);
   assign rx_byte_o = byte_q;

   always_ff @(posedge clk_i) begin
      nib_q <= mii_rxd_i;
      if (state_q == RX_LOW) begin
         low_q <= mii_rxd_i;
      end
      if (state_q == RX_HIGH) begin
         byte_q.data <= {mii_rxd_i, low_q};
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= RX_HUNT;
         dv_q       <= 1'b0;
         first_q    <= 1'b0;
         byte_q.vld <= 1'b0;
         byte_q.sof <= 1'b0;
         byte_q.eof <= 1'b0;
      end else begin
         dv_q       <= mii_rx_dv_i;
         byte_q.vld <= 1'b0;
         byte_q.sof <= 1'b0;
         byte_q.eof <= 1'b0;
         case (state_q)
            RX_HUNT: begin
               if (sfd_seen) begin
                  state_q <= RX_LOW;
                  first_q <= 1'b1;
               end else if (!mii_rx_dv_i && dv_q) begin
                  state_q <= RX_DROP;   // Carrier gone, no SFD found
               end
            end
            RX_LOW: begin
               if (mii_rx_dv_i) begin
                  state_q <= RX_HIGH;
               end else begin
                  byte_q.eof <= 1'b1;   // Clean end on byte boundary
                  state_q    <= RX_HUNT;
               end
            end
            RX_HIGH: begin
               if (mii_rx_dv_i) begin
                  byte_q.vld <= 1'b1;
                  byte_q.sof <= first_q;
                  first_q    <= 1'b0;
                  state_q    <= RX_LOW;
               end else begin
                  byte_q.eof <= 1'b1;   // Odd nibble discarded
                  state_q    <= RX_HUNT;
               end
            end
            default: state_q <= RX_HUNT;   // RX_DROP, nothing emitted
         endcase
      end
   end

endmodule

//--- eth_rx_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Receive buffer writer, CRC residue check
// and held frame status
// ~~~~~~~~~~~~~~~~~~~~

module eth_rx_checker #(
   parameter int BUFFER_W = 6
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  eth_pkg::eth_byte_t  rx_byte_i,
   input  logic                rx_ack_i,
   input  logic [BUFFER_W-1:0] rx_rd_addr_i,
   output logic [7:0]          rx_rd_data_o,
   output logic                rx_data_rcvd_o,
   output logic                rx_crc_err_o,
   output logic [BUFFER_W:0]   rx_nbytes_o
);
   import eth_pkg::*;

   logic [7:0]          rx_mem [2**BUFFER_W];
   logic [BUFFER_W:0]   cnt_q;        // Bytes since SFD, FCS included
   logic [31:0]         crc_q;
   logic                drop_q;       // Current frame started while status held
   logic                rcvd_q;
   logic                crc_err_q;
   logic [BUFFER_W:0]   nbytes_q;
   logic [7:0]          rd_data_q;
   logic                drop;
   logic [BUFFER_W-1:0] wr_addr;
   logic [31:0]         crc_base;

   // First byte restarts address and CRC
   assign drop     = rx_byte_i.sof ? rcvd_q : drop_q;
   assign wr_addr  = rx_byte_i.sof ? '0 : cnt_q[BUFFER_W-1:0];
   assign crc_base = rx_byte_i.sof ? CRC_INIT : crc_q;

   assign rx_rd_data_o   = rd_data_q;
   assign rx_data_rcvd_o = rcvd_q;
   assign rx_crc_err_o   = crc_err_q;
   assign rx_nbytes_o    = nbytes_q;

   always_ff @(posedge clk_i) begin
      if (rx_byte_i.vld && !drop) begin
         rx_mem[wr_addr] <= rx_byte_i.data;
      end
      rd_data_q <= rx_mem[rx_rd_addr_i];   // Host read, one cycle latency
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q     <= '0;
         crc_q     <= CRC_INIT;
         drop_q    <= 1'b0;
         rcvd_q    <= 1'b0;
         crc_err_q <= 1'b0;
         nbytes_q  <= '0;
      end else begin
         if (rx_ack_i) begin
            rcvd_q <= 1'b0;
         end
         if (rx_byte_i.vld) begin
            drop_q <= drop;
            crc_q  <= crc32_byte(crc_base, rx_byte_i.data);
            cnt_q  <= rx_byte_i.sof ? {{BUFFER_W{1'b0}}, 1'b1} : cnt_q + 1'b1;
         end else if (rx_byte_i.eof) begin
            if (!drop_q && !rcvd_q) begin
               rcvd_q    <= 1'b1;                    // Held until ack
               crc_err_q <= (crc_q != CRC_RESIDUE);
               nbytes_q  <= cnt_q;
            end
            drop_q <= 1'b0;
            cnt_q  <= '0;
            crc_q  <= CRC_INIT;
         end
      end
   end

endmodule

//--- eth_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Ethernet MAC top level, TX and RX pipelines
// ~~~~~~~~~~~~~~~~~~~~

module eth_core #(
   parameter int BUFFER_W = 6
) (
   input  logic                clk_i,
   input  logic                reset_i,
   // Host transmit side
   input  logic                tx_wr_i,
   input  logic [BUFFER_W-1:0] tx_addr_i,
   input  logic [7:0]          tx_data_i,
   input  logic                send_i,
   input  logic [BUFFER_W:0]   tx_nbytes_i,
   input  logic                tx_crc_en_i,
   output logic                tx_ready_o,
   // Host receive side
   input  logic                rx_ack_i,
   input  logic [BUFFER_W-1:0] rx_rd_addr_i,
   output logic [7:0]          rx_rd_data_o,
   output logic                rx_data_rcvd_o,
   output logic                rx_crc_err_o,
   output logic [BUFFER_W:0]   rx_nbytes_o,
   // MII pins
   output logic                mii_tx_en_o,
   output logic [3:0]          mii_txd_o,
   input  logic                mii_rx_dv_i,
   input  logic [3:0]          mii_rxd_i
);
   import eth_pkg::*;

   eth_byte_t tx_byte;   // Framer to serializer
   eth_byte_t rx_byte;   // Assembler to checker
   logic      tx_busy;

   eth_tx_framer #(
      .BUFFER_W(BUFFER_W)
   ) u_tx_framer (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .tx_wr_i    (tx_wr_i),
      .tx_addr_i  (tx_addr_i),
      .tx_data_i  (tx_data_i),
      .send_i     (send_i),
      .tx_nbytes_i(tx_nbytes_i),
      .tx_crc_en_i(tx_crc_en_i),
      .tx_busy_i  (tx_busy),
      .tx_ready_o (tx_ready_o),
      .tx_byte_o  (tx_byte)
   );

   eth_mii_tx u_mii_tx (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .tx_byte_i  (tx_byte),
      .mii_tx_en_o(mii_tx_en_o),
      .mii_txd_o  (mii_txd_o),
      .tx_busy_o  (tx_busy)
   );

   eth_mii_rx u_mii_rx (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .mii_rx_dv_i(mii_rx_dv_i),
      .mii_rxd_i  (mii_rxd_i),
      .rx_byte_o  (rx_byte)
   );

   eth_rx_checker #(
      .BUFFER_W(BUFFER_W)
   ) u_rx_checker (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .rx_byte_i     (rx_byte),
      .rx_ack_i      (rx_ack_i),
      .rx_rd_addr_i  (rx_rd_addr_i),
      .rx_rd_data_o  (rx_rd_data_o),
      .rx_data_rcvd_o(rx_data_rcvd_o),
      .rx_crc_err_o  (rx_crc_err_o),
      .rx_nbytes_o   (rx_nbytes_o)
   );

endmodule

//--- eth_core_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on eth_core control outputs
// ~~~~~~~~~~~~~~~~~~~~

module eth_core_props (
   input logic clk_i,
   input logic reset_i,
   input logic mii_tx_en_i,
   input logic tx_ready_i,
   input logic rx_data_rcvd_i,
   input logic rx_ack_i
);

   int unsigned fail_cnt = 0;   // Failed assertion count

   // Host side must see busy while the pins are driven
   a_ready_low: assert property (@(posedge clk_i) disable iff (reset_i)
      mii_tx_en_i |-> !tx_ready_i)
      else begin
         $error("tx_ready_o high while mii_tx_en_o high");
         fail_cnt++;
      end

   a_reset_quiet: assert property (@(posedge clk_i) reset_i |=> !mii_tx_en_i)
      else begin
         $error("mii_tx_en_o high during reset");
         fail_cnt++;
      end

   // Status only clears on ack
   a_rcvd_held: assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(rx_data_rcvd_i) |-> $past(rx_ack_i))
      else begin
         $error("rx_data_rcvd_o fell without rx_ack_i");
         fail_cnt++;
      end

endmodule

bind eth_core eth_core_props u_props (
   .clk_i         (clk_i),
   .reset_i       (reset_i),
   .mii_tx_en_i   (mii_tx_en_o),
   .tx_ready_i    (tx_ready_o),
   .rx_data_rcvd_i(rx_data_rcvd_o),
   .rx_ack_i      (rx_ack_i)
);

//--- eth_core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Loopback testbench for eth_core, reference nibble model,
// LCG stimulus, nibble monitor and frame status checks
// ~~~~~~~~~~~~~~~~~~~~

module eth_core_tb;
   localparam int BUFFER_W  = 6;
   localparam int SEL_TX_EN = 0;
   localparam int SEL_READY = 1;
   localparam int SEL_RCVD  = 2;
   typedef logic [7:0] byte_q_t [$];

   logic                clk = 1'b0;
   logic                reset;
   logic                tx_wr;
   logic [BUFFER_W-1:0] tx_addr;
   logic [7:0]          tx_data;
   logic                send;
   logic [BUFFER_W:0]   tx_nbytes;
   logic                tx_crc_en;
   logic                tx_ready;
   logic                rx_ack;
   logic [BUFFER_W-1:0] rx_rd_addr;
   logic [7:0]          rx_rd_data;
   logic                rx_data_rcvd;
   logic                rx_crc_err;
   logic [BUFFER_W:0]   rx_nbytes;
   logic                mii_tx_en;
   logic [3:0]          mii_txd;
   logic                mii_rx_dv;
   logic [3:0]          mii_rxd;

   logic [31:0] lcg_state = 32'h20b949fc;
   logic [7:0]  payload [64];
   logic [3:0]  exp_nibs [$];   // Full frame as seen on the pins
   byte_q_t     exp_bytes;      // Bytes after SFD
   int          nib_cnt = 0;    // Index of nibble on the pins
   int          flip_idx = -1;  // Nibble to corrupt, -1 for none
   logic [3:0]  flip_mask = 4'h0;

   always #50 clk = ~clk;

   eth_core #(
      .BUFFER_W(BUFFER_W)
   ) DUT (
      .clk_i(clk), .reset_i(reset),
      .tx_wr_i(tx_wr), .tx_addr_i(tx_addr), .tx_data_i(tx_data),
      .send_i(send), .tx_nbytes_i(tx_nbytes), .tx_crc_en_i(tx_crc_en),
      .tx_ready_o(tx_ready),
      .rx_ack_i(rx_ack), .rx_rd_addr_i(rx_rd_addr), .rx_rd_data_o(rx_rd_data),
      .rx_data_rcvd_o(rx_data_rcvd), .rx_crc_err_o(rx_crc_err), .rx_nbytes_o(rx_nbytes),
      .mii_tx_en_o(mii_tx_en), .mii_txd_o(mii_txd),
      .mii_rx_dv_i(mii_rx_dv), .mii_rxd_i(mii_rxd)
   );

   // Loopback with optional single nibble corruption
   assign mii_rx_dv = mii_tx_en;
   assign mii_rxd   = mii_txd ^ ((nib_cnt == flip_idx) ? flip_mask : 4'h0);

   always @(posedge clk) begin
      if (reset) begin
         nib_cnt <= 0;
      end else begin
         nib_cnt <= mii_tx_en ? nib_cnt + 1 : 0;   // Nibble k shown while cnt is k
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_len();
      logic [31:0] r;
      r = lcg_next();
      return 1 + int'(r[15:0] % 16'd60);   // n + 4 fits the 64 byte buffer
   endfunction

   // Reflected CRC-32 step, LSB first
   function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'h0, data};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
      return c;
   endfunction

   // Reference frame: preamble, SFD, payload, inverted CRC LSB first
   function automatic void build_expected(input int n, input logic crc_en);
      logic [31:0] crc;
      crc = 32'hFFFF_FFFF;
      exp_bytes = {};
      exp_nibs  = {};
      for (int i = 0; i < n; i++) begin
         exp_bytes.push_back(payload[i]);
         crc = crc_step(crc, payload[i]);
      end
      if (crc_en) begin
         for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(~crc[8*i +: 8]);
         end
      end
      for (int i = 0; i < 14; i++) begin
         exp_nibs.push_back(4'h5);
      end
      exp_nibs.push_back(4'h5);   // SFD low then high
      exp_nibs.push_back(4'hD);
      foreach (exp_bytes[i]) begin
         exp_nibs.push_back(exp_bytes[i][3:0]);
         exp_nibs.push_back(exp_bytes[i][7:4]);
      end
   endfunction

   // Residue rule over received bytes, with the corrupted nibble applied
   function automatic logic residue_error(input int at, input logic [3:0] mask);
      logic [31:0] crc;
      logic [7:0]  b;
      crc = 32'hFFFF_FFFF;
      foreach (exp_bytes[i]) begin
         b = exp_bytes[i];
         if (at >= 16 && (at - 16) / 2 == i) begin
            b = b ^ ((at % 2 == 1) ? {mask, 4'h0} : {4'h0, mask});
         end
         crc = crc_step(crc, b);
      end
      return crc != 32'hDEBB_20E3;
   endfunction

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Fail at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic logic probe(input int sel);
      case (sel)
         SEL_TX_EN: return mii_tx_en;
         SEL_READY: return tx_ready;
         default:   return rx_data_rcvd;
      endcase
   endfunction

   // Counts falling edges until the level shows up
   task automatic wait_level(input int sel, input logic level, input int limit,
                             input string what, output int cycles);
      cycles = 0;
      while (probe(sel) !== level) begin
         if (cycles >= limit) begin
            $display("Timeout at time %0t: %s never happened", $time, what);
            $display("Checks failed");
            $fatal(1, "wait timed out");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   // Tx nibbles checked as they leave the pins
   always @(negedge clk) begin
      if (mii_tx_en === 1'b1) begin
         compare(mii_txd, exp_nibs[nib_cnt], $sformatf("tx nibble %0d", nib_cnt));
      end
   end

   // Bound assertion counter watched every cycle
   always @(negedge clk) begin
      if (DUT.u_props.fail_cnt != 0) begin
         $display("A concurrent assertion failed by time %0t", $time);
         $display("Checks failed");
         $fatal(1, "assertion failed");
      end
   end

   task automatic send_frame(input int n, input logic crc_en);
      int          cycles;
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r          = lcg_next();
         payload[i] = r[23:16];
         tx_wr      = 1'b1;
         tx_addr    = i;
         tx_data    = payload[i];
         @(negedge clk);
      end
      tx_wr = 1'b0;
      build_expected(n, crc_en);
      tx_nbytes = n;
      tx_crc_en = crc_en;
      send      = 1'b1;
      @(negedge clk);
      send = 1'b0;
      wait_level(SEL_TX_EN, 1'b1, 8, "mii_tx_en_o rise after send_i", cycles);
      compare(cycles + 1, 2, "cycles from send_i to mii_tx_en_o");
      wait_level(SEL_TX_EN, 1'b0, 300, "mii_tx_en_o fall at frame end", cycles);
      compare(cycles, crc_en ? 2 * (8 + n + 4) : 2 * (8 + n), "mii_tx_en_o length");
      wait_level(SEL_READY, 1'b1, 4, "tx_ready_o return after frame", cycles);
      compare(cycles, 1, "cycles from mii_tx_en_o fall to tx_ready_o");
   endtask

   task automatic check_rx(input logic crc_err, input int nbytes);
      int cycles;
      wait_level(SEL_RCVD, 1'b1, 4, "rx_data_rcvd_o rise after frame", cycles);
      compare(rx_crc_err, crc_err, "rx_crc_err_o");
      compare(rx_nbytes, nbytes, "rx_nbytes_o");
   endtask

   task automatic check_rx_buffer(input byte_q_t bytes);
      foreach (bytes[i]) begin
         rx_rd_addr = i;
         @(negedge clk);   // Registered read
         compare(rx_rd_data, bytes[i], $sformatf("rx buffer byte %0d", i));
      end
   endtask

   task automatic ack_frame();
      rx_ack = 1'b1;
      @(negedge clk);
      rx_ack = 1'b0;
      compare(rx_data_rcvd, 1'b0, "rx_data_rcvd_o after ack");
   endtask

   initial begin
      int          n;
      int          held_n;
      logic        held_err;
      byte_q_t     held_bytes;
      logic [31:0] r;
      reset      = 1'b1;
      tx_wr      = 1'b0;
      tx_addr    = '0;
      tx_data    = '0;
      send       = 1'b0;
      tx_nbytes  = '0;
      tx_crc_en  = 1'b0;
      rx_ack     = 1'b0;
      rx_rd_addr = '0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      compare(tx_ready, 1'b1, "tx_ready_o after reset");
      compare(mii_tx_en, 1'b0, "mii_tx_en_o after reset");
      compare(rx_data_rcvd, 1'b0, "rx_data_rcvd_o after reset");
      compare(rx_crc_err, 1'b0, "rx_crc_err_o after reset");
      compare(rx_nbytes, 0, "rx_nbytes_o after reset");

      n = rand_len();   // Good frame, FCS appended
      send_frame(n, 1'b1);
      check_rx(residue_error(-1, 4'h0), n + 4);
      check_rx_buffer(exp_bytes);
      ack_frame();

      n = rand_len();   // One payload nibble flipped
      r = lcg_next();
      flip_idx  = 16 + int'(r[15:0]) % (2 * n);
      flip_mask = 4'h1 << r[17:16];
      send_frame(n, 1'b1);
      check_rx(residue_error(flip_idx, flip_mask), n + 4);
      flip_idx = -1;
      ack_frame();

      n = rand_len();   // No FCS
      send_frame(n, 1'b0);
      check_rx(residue_error(-1, 4'h0), n);
      check_rx_buffer(exp_bytes);
      held_bytes = exp_bytes;
      held_n     = n;
      held_err   = residue_error(-1, 4'h0);

      send_frame(rand_len(), 1'b1);   // Dropped, status still held
      repeat (4) @(negedge clk);      // Past the receive latency
      compare(rx_data_rcvd, 1'b1, "rx_data_rcvd_o while held");
      compare(rx_crc_err, held_err, "rx_crc_err_o while held");
      compare(rx_nbytes, held_n, "rx_nbytes_o while held");
      check_rx_buffer(held_bytes);
      ack_frame();

      n = rand_len();
      send_frame(n, 1'b1);
      check_rx(residue_error(-1, 4'h0), n + 4);
      check_rx_buffer(exp_bytes);
      ack_frame();

      if (DUT.u_props.fail_cnt == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Assertion failures: %0d", DUT.u_props.fail_cnt);
         $display("Checks failed");
         $fatal(1, "assertion failed");
      end
   end

endmodule

//--- vlog.f
eth_pkg.sv
eth_tx_framer.sv
eth_mii_tx.sv
eth_mii_rx.sv
eth_rx_checker.sv
eth_core.sv
eth_core_props.sv
eth_core_tb.sv
